// File: all.f
hdl/bpu_pkg.sv
hdl/inst_predecode.sv
hdl/bimodal_table.sv
hdl/branch_target_buffer.sv
hdl/return_addr_stack.sv
hdl/bpu_top.sv
dv/bpu_checker.sv
dv/bpu_tb.sv

// File: dv/bpu_checker.sv
`timescale 1ns/1ps

module bpu_checker (
    input  logic        clk,
    input  logic        check_en_i,
    input  logic [3:0]  test_idx_i,
    input  logic        test_end_i,
    input  logic        pred_valid_i,
    input  logic        pred_taken_i,
    input  logic [31:0] pred_pc_i,
    input  logic        exp_valid_i,
    input  logic        exp_taken_i,
    input  logic [31:0] exp_pc_i,
    output int          tests_passed_o,
    output int          error_count_o
);

    int test_errors;  // mismatches inside the running test

    function automatic string test_name(logic [3:0] idx);
        case (idx)
            4'd1:    return "after reset";
            4'd2:    return "bimodal training";
            4'd3:    return "btb target";
            4'd4:    return "return stack";
            4'd5:    return "ras bypass and push/pop";
            default: return "unknown";
        endcase
    endfunction

    task automatic compare_value(string name, logic [31:0] exp_val, logic [31:0] act_val);
        if (act_val !== exp_val) begin
            $display("** Error at %0t ns: %s expected %0h, got %0h",
                     $time, name, exp_val, act_val);
            error_count_o = error_count_o + 1;
            test_errors   = test_errors + 1;
        end
    endtask

    initial begin
        tests_passed_o = 0;
        error_count_o  = 0;
        test_errors    = 0;
    end

    // mid cycle, long after the row was driven
    always @(negedge clk) begin
        if (check_en_i) begin
            compare_value("pred_valid_o", {31'd0, exp_valid_i}, {31'd0, pred_valid_i});
            compare_value("pred_taken_o", {31'd0, exp_taken_i}, {31'd0, pred_taken_i});
            compare_value("pred_pc_o", exp_pc_i, pred_pc_i);
            if (test_end_i) begin
                if (test_errors == 0) begin
                    $display("test %0d (%s): pass", test_idx_i, test_name(test_idx_i));
                    tests_passed_o = tests_passed_o + 1;
                end else begin
                    $display("test %0d (%s): fail, %0d errors",
                             test_idx_i, test_name(test_idx_i), test_errors);
                end
                test_errors = 0;
            end
        end
    end

endmodule

// File: dv/bpu_tb.sv
`timescale 1ns/1ps

module bpu_tb;

    localparam int RESET_CYCLES = 16;
    localparam int NUM_TESTS    = 5;
    localparam logic [31:0] ADD_WORD = 32'h00c58533;  // add a0, a1, a2
    localparam logic [31:0] FILL_PC  = 32'h00000500;

    typedef struct packed {
        logic [31:0] if_pc;
        logic [31:0] if_inst;
        logic        ex_valid;
        logic        ex_taken;
        logic [31:0] ex_pc;
        logic [31:0] ex_target;
        logic [31:0] ex_inst;
        logic        push_valid;
        logic [31:0] push_data;
        logic        id_stall;
        logic        ex_stall;
        logic        exp_valid;
        logic        exp_taken;
        logic [31:0] exp_pc;
        logic [3:0]  test;
        logic        last;
    } row_t;

    logic        clk;
    logic        rst;
    logic [31:0] if_pc, if_inst, ex_pc, ex_target, ex_inst, push_data, pred_pc;
    logic        ex_valid, ex_taken, push_valid, ex_stall, id_stall;
    logic        pred_valid, pred_taken;
    logic        exp_valid, exp_taken, check_en, test_end;
    logic [31:0] exp_pc;
    logic [3:0]  test_idx;
    int          tests_passed, error_count, cycle_count, cycle_limit, seed, rnd;
    row_t        rows[$];
    logic [21:0] up1, up2;  // random upper pc bits
    logic [31:0] p_br, p_tgt, q_jal, q_miss, x_tgt, ret_pc, ret_ra, ret_t0, br_word;

    bpu_top i_bpu_top (
        .clk(clk), .rst(rst),
        .if_pc_i(if_pc), .if_inst_i(if_inst),
        .ex_branch_valid_i(ex_valid), .ex_branch_taken_i(ex_taken),
        .ex_pc_i(ex_pc), .ex_target_i(ex_target), .ex_inst_i(ex_inst),
        .id_ras_push_valid_i(push_valid), .id_ras_push_data_i(push_data),
        .ex_stall_i(ex_stall), .id_stall_i(id_stall),
        .pred_valid_o(pred_valid), .pred_taken_o(pred_taken), .pred_pc_o(pred_pc)
    );

    bpu_checker i_checker (
        .clk(clk), .check_en_i(check_en), .test_idx_i(test_idx), .test_end_i(test_end),
        .pred_valid_i(pred_valid), .pred_taken_i(pred_taken), .pred_pc_i(pred_pc),
        .exp_valid_i(exp_valid), .exp_taken_i(exp_taken), .exp_pc_i(exp_pc),
        .tests_passed_o(tests_passed), .error_count_o(error_count)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // instruction encoders
    function automatic logic [31:0] branch_word(logic [31:0] off);
        bpu_pkg::inst_word_t w;
        w = '0;
        w.b.opcode  = bpu_pkg::OPC_BRANCH;  // beq a0, a1
        w.b.rs1     = 5'd10;
        w.b.rs2     = 5'd11;
        w.b.imm12   = off[12];
        w.b.imm11   = off[11];
        w.b.imm10_5 = off[10:5];
        w.b.imm4_1  = off[4:1];
        return w;
    endfunction

    function automatic logic [31:0] jal_word(logic [31:0] off);
        bpu_pkg::inst_word_t w;
        w = '0;
        w.j.opcode   = bpu_pkg::OPC_JAL;
        w.j.rd       = bpu_pkg::REG_RA;
        w.j.imm20    = off[20];
        w.j.imm19_12 = off[19:12];
        w.j.imm11    = off[11];
        w.j.imm10_1  = off[10:1];
        return w;
    endfunction

    function automatic logic [31:0] jalr_word(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        bpu_pkg::inst_word_t w;
        w = '0;
        w.i.opcode = bpu_pkg::OPC_JALR;
        w.i.rd     = rd;
        w.i.rs1    = rs1;
        w.i.imm    = imm;
        return w;
    endfunction

    function automatic row_t fetch_row(logic [31:0] pc, logic [31:0] inst,
                                       logic v, logic t, logic [31:0] npc);
        row_t r;
        r = '0;
        r.if_pc     = pc;
        r.if_inst   = inst;
        r.exp_valid = v;
        r.exp_taken = t;
        r.exp_pc    = npc;
        return r;
    endfunction

    // plain add on the fetch port
    function automatic row_t idle_row();
        return fetch_row(FILL_PC, ADD_WORD, 1'b0, 1'b0, FILL_PC + 32'd4);
    endfunction

    function automatic row_t add_resolve(row_t r, logic taken, logic [31:0] pc,
                                         logic [31:0] target, logic [31:0] inst);
        r.ex_valid  = 1'b1;
        r.ex_taken  = taken;
        r.ex_pc     = pc;
        r.ex_target = target;
        r.ex_inst   = inst;
        return r;
    endfunction

    function automatic row_t add_push(row_t r, logic [31:0] data, logic stall);
        r.push_valid = 1'b1;
        r.push_data  = data;
        r.id_stall   = stall;
        return r;
    endfunction

    // execute stall holds back both stack ports
    function automatic row_t add_ex_stall(row_t r);
        r.ex_stall = 1'b1;
        return r;
    endfunction

    task automatic append_row(row_t r, logic [3:0] test, logic last);
        r.test = test;
        r.last = last;
        rows.push_back(r);
    endtask

    task automatic build_table();
        // 1: counters at 01, nothing predicted taken
        append_row(fetch_row({up1, 10'h010}, ADD_WORD, 1'b0, 1'b0, {up1, 10'h014}), 1, 0);
        append_row(fetch_row({up1, 10'h040}, branch_word(-32'sd16), 1'b1, 1'b0,
                             {up1, 10'h044}), 1, 0);
        append_row(fetch_row({up1, 10'h060}, jalr_word(5'd1, 5'd6, 12'd8), 1'b1, 1'b0,
                             {up1, 10'h064}), 1, 1);
        // 2: train, untrain, saturate
        append_row(add_resolve(idle_row(), 1'b1, p_br, p_tgt, br_word), 2, 0);
        append_row(fetch_row(p_br, br_word, 1'b1, 1'b1, p_tgt), 2, 0);
        append_row(add_resolve(idle_row(), 1'b0, p_br, p_tgt, br_word), 2, 0);
        append_row(add_resolve(idle_row(), 1'b0, p_br, p_tgt, br_word), 2, 0);
        append_row(fetch_row(p_br, br_word, 1'b1, 1'b0, p_br + 32'd4), 2, 0);
        repeat (3) append_row(add_resolve(idle_row(), 1'b1, p_br, p_tgt, br_word), 2, 0);
        append_row(add_resolve(idle_row(), 1'b0, p_br, p_tgt, br_word), 2, 0);
        append_row(fetch_row(p_br, br_word, 1'b1, 1'b1, p_tgt), 2, 1);
        // 3: btb hit overrides pc + offset, tag miss does not
        append_row(add_resolve(idle_row(), 1'b1, q_jal, x_tgt, jal_word(32'd256)), 3, 0);
        append_row(fetch_row(q_jal, jal_word(32'd256), 1'b1, 1'b1, x_tgt), 3, 0);
        append_row(fetch_row(q_miss, jal_word(32'd256), 1'b1, 1'b1, q_miss + 32'd256), 3, 1);
        // 4: two calls, two returns, then empty; stalled pop and pushes dropped
        append_row(add_push(idle_row(), 32'h00001004, 1'b0), 4, 0);
        append_row(add_push(idle_row(), 32'h00002008, 1'b0), 4, 0);
        append_row(add_ex_stall(add_resolve(idle_row(), 1'b1, ret_pc, 32'h00002008,
                                            ret_t0)), 4, 0);
        append_row(fetch_row(ret_pc, ret_ra, 1'b1, 1'b1, 32'h00002008), 4, 0);
        append_row(add_resolve(idle_row(), 1'b1, ret_pc, 32'h00002008, ret_t0), 4, 0);
        append_row(fetch_row(ret_pc, ret_ra, 1'b1, 1'b1, 32'h00001004), 4, 0);
        append_row(add_resolve(idle_row(), 1'b1, ret_pc, 32'h00001004, ret_t0), 4, 0);
        append_row(fetch_row(ret_pc, ret_ra, 1'b1, 1'b0, ret_pc + 32'd4), 4, 0);
        append_row(add_push(idle_row(), 32'h0000300c, 1'b1), 4, 0);
        append_row(add_ex_stall(add_push(idle_row(), 32'h0000300c, 1'b0)), 4, 0);
        append_row(fetch_row(ret_pc, ret_ra, 1'b1, 1'b0, ret_pc + 32'd4), 4, 1);
        // 5: bypass on an empty stack, then push and pop together
        append_row(add_push(fetch_row(ret_pc, ret_t0, 1'b1, 1'b1, 32'h0000400c),
                            32'h0000400c, 1'b0), 5, 0);
        append_row(fetch_row(ret_pc, ret_ra, 1'b1, 1'b1, 32'h0000400c), 5, 0);
        append_row(add_resolve(add_push(idle_row(), 32'h00005010, 1'b0), 1'b1, ret_pc,
                               32'h0000400c, ret_ra), 5, 0);
        append_row(fetch_row(ret_pc, ret_ra, 1'b1, 1'b1, 32'h00005010), 5, 0);
        append_row(add_resolve(idle_row(), 1'b1, ret_pc, 32'h00005010, ret_ra), 5, 0);
        append_row(fetch_row(ret_pc, ret_ra, 1'b1, 1'b0, ret_pc + 32'd4), 5, 1);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        {if_pc, ex_pc, ex_target, push_data, exp_pc} = '0;
        {ex_valid, ex_taken, push_valid, ex_stall, id_stall} = '0;
        {exp_valid, exp_taken, check_en, test_end} = '0;
        {if_inst, ex_inst, test_idx} = {ADD_WORD, ADD_WORD, 4'd0};
        rst = 1'b1;
        cycle_count = 0;
        cycle_limit = 0;
        seed = 72;
        rnd = $random(seed);
        up1 = rnd[21:0];
        rnd = $random(seed);
        up2 = up1 ^ (rnd[21:0] | 22'd1);  // never equal to up1
        br_word = branch_word(32'd64);
        p_br    = {up1, 10'h104};
        p_tgt   = p_br + 32'd64;
        q_jal   = {up1, 10'h208};
        q_miss  = {up2, 10'h208};
        x_tgt   = 32'h00012340;
        ret_pc  = {up1, 10'h300};
        ret_ra  = jalr_word(5'd0, bpu_pkg::REG_RA, 12'd0);
        ret_t0  = jalr_word(5'd0, bpu_pkg::REG_T0, 12'd0);
        build_table();
        cycle_limit = RESET_CYCLES + rows.size() + 20;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        foreach (rows[n]) begin
            @(posedge clk);
            if_pc      <= rows[n].if_pc;
            if_inst    <= rows[n].if_inst;
            ex_valid   <= rows[n].ex_valid;
            ex_taken   <= rows[n].ex_taken;
            ex_pc      <= rows[n].ex_pc;
            ex_target  <= rows[n].ex_target;
            ex_inst    <= rows[n].ex_inst;
            push_valid <= rows[n].push_valid;
            push_data  <= rows[n].push_data;
            id_stall   <= rows[n].id_stall;
            ex_stall   <= rows[n].ex_stall;
            exp_valid  <= rows[n].exp_valid;
            exp_taken  <= rows[n].exp_taken;
            exp_pc     <= rows[n].exp_pc;
            test_idx   <= rows[n].test;
            test_end   <= rows[n].last;
            check_en   <= 1'b1;
        end
        @(posedge clk);  // last row checked at the negedge before
        check_en <= 1'b0;
        $display("summary: %0d of %0d tests ok, %0d errors", tests_passed, NUM_TESTS, error_count);
        if (error_count == 0 && tests_passed == NUM_TESTS) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: hdl/bimodal_table.sv
`timescale 1ns/1ps

module bimodal_table (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [bpu_pkg::BM_IDX_W-1:0] rd_idx_i,
    output logic                         taken_o,
    input  logic                         wr_en_i,
    input  logic [bpu_pkg::BM_IDX_W-1:0] wr_idx_i,
    input  logic                         wr_taken_i
);

    logic [1:0] cnt_q [bpu_pkg::BIMODAL_ENTRIES];

    logic [1:0] cur_cnt;
    logic [1:0] nxt_cnt;

    // prediction is the counter msb
    assign taken_o = cnt_q[rd_idx_i][1];

    assign cur_cnt = cnt_q[wr_idx_i];

    // saturating step toward the resolved direction
    always_comb begin
        nxt_cnt = cur_cnt;
        if (wr_taken_i) begin
            if (cur_cnt != 2'b11) begin
                nxt_cnt = cur_cnt + 2'd1;
            end
        end else begin
            if (cur_cnt != 2'b00) begin
                nxt_cnt = cur_cnt - 2'd1;
            end
        end
    end

    // every counter starts weakly not taken
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < bpu_pkg::BIMODAL_ENTRIES; i++) begin
                cnt_q[i] <= bpu_pkg::CNT_WEAK_NT;
            end
        end else if (wr_en_i) begin
            cnt_q[wr_idx_i] <= nxt_cnt;  // lands at the strobe edge
        end
    end

endmodule

// File: hdl/bpu_pkg.sv
package bpu_pkg;

    localparam int XLEN = 32;

    // bimodal direction table
    localparam int BIMODAL_ENTRIES = 512;
    localparam int BM_IDX_W        = 9;
    localparam int BM_IDX_LSB      = 1;   // pc[9:1]

    // branch target buffer
    localparam int BTB_ENTRIES = 256;
    localparam int BTB_IDX_W   = 8;
    localparam int BTB_IDX_LSB = 2;       // pc[9:2]
    localparam int BTB_TAG_W   = 22;
    localparam int BTB_TAG_LSB = 10;      // pc[31:10]

    // return address stack, pointer counts 0..64
    localparam int RAS_DEPTH = 64;
    localparam int RAS_PTR_W = 7;

    // control-flow opcodes
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    // link registers that mark a return source
    localparam logic [4:0] REG_RA = 5'd1;
    localparam logic [4:0] REG_T0 = 5'd5;

    localparam logic [1:0] CNT_WEAK_NT = 2'b01;  // counter reset value

    // one instruction word, seen as B, J or I format
    typedef union packed {
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
    } inst_word_t;

endpackage

// File: hdl/bpu_top.sv
`timescale 1ns/1ps

module bpu_top (
    input  logic                     clk,
    input  logic                     rst,
    // fetch
    input  logic [bpu_pkg::XLEN-1:0] if_pc_i,
    input  logic [bpu_pkg::XLEN-1:0] if_inst_i,
    // execute feedback
    input  logic                     ex_branch_valid_i,
    input  logic                     ex_branch_taken_i,
    input  logic [bpu_pkg::XLEN-1:0] ex_pc_i,
    input  logic [bpu_pkg::XLEN-1:0] ex_target_i,
    input  logic [bpu_pkg::XLEN-1:0] ex_inst_i,
    // decode push
    input  logic                     id_ras_push_valid_i,
    input  logic [bpu_pkg::XLEN-1:0] id_ras_push_data_i,
    input  logic                     ex_stall_i,
    input  logic                     id_stall_i,
    // prediction
    output logic                     pred_valid_o,
    output logic                     pred_taken_o,
    output logic [bpu_pkg::XLEN-1:0] pred_pc_o
);

    logic                         if_is_branch;
    logic                         if_is_jal;
    logic                         if_is_jalr;
    logic                         if_is_ret;
    logic [bpu_pkg::XLEN-1:0]     if_b_imm;
    logic [bpu_pkg::XLEN-1:0]     if_j_imm;
    logic                         ex_is_ret;

    logic [bpu_pkg::BM_IDX_W-1:0] bm_rd_idx;
    logic [bpu_pkg::BM_IDX_W-1:0] bm_wr_idx;
    logic                         bm_taken;
    logic                         btb_hit;
    logic [bpu_pkg::XLEN-1:0]     btb_target;
    logic                         btb_fill;
    logic                         ras_push;
    logic                         ras_pop;
    logic [bpu_pkg::XLEN-1:0]     ras_top;
    logic                         ras_empty;
    logic [bpu_pkg::XLEN-1:0]     pc_seq;

    inst_predecode u_if_dec (
        .inst_i      (if_inst_i),
        .is_branch_o (if_is_branch),
        .is_jal_o    (if_is_jal),
        .is_jalr_o   (if_is_jalr),
        .is_ret_o    (if_is_ret),
        .b_imm_o     (if_b_imm),
        .j_imm_o     (if_j_imm)
    );

    // execute side only needs the return flag
    inst_predecode u_ex_dec (
        .inst_i      (ex_inst_i),
        .is_branch_o (),
        .is_jal_o    (),
        .is_jalr_o   (),
        .is_ret_o    (ex_is_ret),
        .b_imm_o     (),
        .j_imm_o     ()
    );

    assign bm_rd_idx = if_pc_i[bpu_pkg::BM_IDX_LSB +: bpu_pkg::BM_IDX_W];
    assign bm_wr_idx = ex_pc_i[bpu_pkg::BM_IDX_LSB +: bpu_pkg::BM_IDX_W];
    assign btb_fill  = ex_branch_valid_i && ex_branch_taken_i;

    // stalls only hold back stack changes
    assign ras_push = id_ras_push_valid_i && !id_stall_i && !ex_stall_i;
    assign ras_pop  = ex_branch_valid_i && ex_branch_taken_i && ex_is_ret && !ex_stall_i;

    bimodal_table u_bimodal (
        .clk        (clk),
        .rst        (rst),
        .rd_idx_i   (bm_rd_idx),
        .taken_o    (bm_taken),
        .wr_en_i    (ex_branch_valid_i),  // every resolved control instruction
        .wr_idx_i   (bm_wr_idx),
        .wr_taken_i (ex_branch_taken_i)
    );

    branch_target_buffer u_btb (
        .clk           (clk),
        .rst           (rst),
        .rd_pc_i       (if_pc_i),
        .hit_o         (btb_hit),
        .target_o      (btb_target),
        .fill_i        (btb_fill),
        .fill_pc_i     (ex_pc_i),
        .fill_target_i (ex_target_i)
    );

    return_addr_stack u_ras (
        .clk         (clk),
        .rst         (rst),
        .push_i      (ras_push),
        .push_data_i (id_ras_push_data_i),
        .pop_i       (ras_pop),
        .top_o       (ras_top),
        .empty_o     (ras_empty)
    );

    assign pc_seq = if_pc_i + 4;

    // next pc select
    always_comb begin
        pred_valid_o = if_is_branch || if_is_jal || if_is_jalr;
        pred_taken_o = 1'b0;
        pred_pc_o    = pc_seq;
        if (if_is_ret) begin
            if (id_ras_push_valid_i) begin
                pred_taken_o = 1'b1;
                pred_pc_o    = id_ras_push_data_i;  // bypass the call being decoded
            end else if (!ras_empty) begin
                pred_taken_o = 1'b1;
                pred_pc_o    = ras_top;
            end
        end else if (if_is_jal) begin
            pred_taken_o = 1'b1;
            pred_pc_o    = btb_hit ? btb_target : (if_pc_i + if_j_imm);
        end else if (if_is_branch || if_is_jalr) begin
            pred_taken_o = bm_taken;
            if (bm_taken) begin
                if (btb_hit) begin
                    pred_pc_o = btb_target;
                end else if (if_is_branch) begin
                    pred_pc_o = if_pc_i + if_b_imm;
                end
            end
        end
    end

endmodule

// File: hdl/branch_target_buffer.sv
`timescale 1ns/1ps

module branch_target_buffer (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [bpu_pkg::XLEN-1:0] rd_pc_i,
    output logic                     hit_o,
    output logic [bpu_pkg::XLEN-1:0] target_o,
    input  logic                     fill_i,
    input  logic [bpu_pkg::XLEN-1:0] fill_pc_i,
    input  logic [bpu_pkg::XLEN-1:0] fill_target_i
);

    logic                          valid_q  [bpu_pkg::BTB_ENTRIES];
    logic [bpu_pkg::BTB_TAG_W-1:0] tag_q    [bpu_pkg::BTB_ENTRIES];
    logic [bpu_pkg::XLEN-1:0]      target_q [bpu_pkg::BTB_ENTRIES];

    logic [bpu_pkg::BTB_IDX_W-1:0] rd_idx;
    logic [bpu_pkg::BTB_TAG_W-1:0] rd_tag;
    logic [bpu_pkg::BTB_IDX_W-1:0] fill_idx;
    logic [bpu_pkg::BTB_TAG_W-1:0] fill_tag;

    // index from pc[9:2], tag from pc[31:10]
    assign rd_idx   = rd_pc_i[bpu_pkg::BTB_IDX_LSB +: bpu_pkg::BTB_IDX_W];
    assign rd_tag   = rd_pc_i[bpu_pkg::BTB_TAG_LSB +: bpu_pkg::BTB_TAG_W];
    assign fill_idx = fill_pc_i[bpu_pkg::BTB_IDX_LSB +: bpu_pkg::BTB_IDX_W];
    assign fill_tag = fill_pc_i[bpu_pkg::BTB_TAG_LSB +: bpu_pkg::BTB_TAG_W];

    // direct mapped, one compare
    assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign target_o = target_q[rd_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < bpu_pkg::BTB_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (fill_i) begin
            valid_q[fill_idx] <= 1'b1;
        end
    end

    // tag and target storage
    always_ff @(posedge clk) begin
        if (fill_i) begin
            tag_q[fill_idx]    <= fill_tag;
            target_q[fill_idx] <= fill_target_i;  // overwrites any older entry
        end
    end

endmodule

// File: hdl/inst_predecode.sv
`timescale 1ns/1ps

module inst_predecode (
    input  logic [bpu_pkg::XLEN-1:0] inst_i,
    output logic                     is_branch_o,
    output logic                     is_jal_o,
    output logic                     is_jalr_o,
    output logic                     is_ret_o,
    output logic [bpu_pkg::XLEN-1:0] b_imm_o,
    output logic [bpu_pkg::XLEN-1:0] j_imm_o
);

    bpu_pkg::inst_word_t iw;

    logic rd_is_zero;
    logic rs1_is_link;
    logic imm_is_zero;

    assign iw = inst_i;

    // opcode classes, all formats share bits 6:0
    assign is_branch_o = (iw.b.opcode == bpu_pkg::OPC_BRANCH);
    assign is_jal_o    = (iw.j.opcode == bpu_pkg::OPC_JAL);
    assign is_jalr_o   = (iw.i.opcode == bpu_pkg::OPC_JALR);

    // return is jalr x0, 0(ra) or jalr x0, 0(t0)
    assign rd_is_zero  = (iw.i.rd == 5'd0);
    assign rs1_is_link = (iw.i.rs1 == bpu_pkg::REG_RA) || (iw.i.rs1 == bpu_pkg::REG_T0);
    assign imm_is_zero = (iw.i.imm == 12'd0);

    assign is_ret_o = is_jalr_o && rd_is_zero && rs1_is_link && imm_is_zero;

    // b-type offset, 13 bits sign extended
    assign b_imm_o = {
        {(bpu_pkg::XLEN-12){iw.b.imm12}},
        iw.b.imm11,
        iw.b.imm10_5,
        iw.b.imm4_1,
        1'b0
    };

    // j-type offset, 21 bits sign extended
    assign j_imm_o = {
        {(bpu_pkg::XLEN-20){iw.j.imm20}},
        iw.j.imm19_12,
        iw.j.imm11,
        iw.j.imm10_1,
        1'b0
    };

endmodule

// File: hdl/return_addr_stack.sv
`timescale 1ns/1ps

module return_addr_stack (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     push_i,
    input  logic [bpu_pkg::XLEN-1:0] push_data_i,
    input  logic                     pop_i,
    output logic [bpu_pkg::XLEN-1:0] top_o,
    output logic                     empty_o
);

    logic [bpu_pkg::XLEN-1:0] stack_q [bpu_pkg::RAS_DEPTH];

    logic [bpu_pkg::RAS_PTR_W-1:0] sp_q;        // next free slot
    logic [bpu_pkg::RAS_PTR_W-1:0] sp_dec;
    logic [bpu_pkg::RAS_PTR_W-1:0] sp_popped;
    logic [bpu_pkg::RAS_PTR_W-1:0] sp_nxt;
    logic [bpu_pkg::RAS_PTR_W-2:0] top_idx;
    logic [bpu_pkg::RAS_PTR_W-2:0] wr_idx;
    logic                          do_pop;
    logic                          do_push;

    assign sp_dec  = sp_q - 1'b1;
    assign top_idx = sp_dec[bpu_pkg::RAS_PTR_W-2:0];

    // status straight from the pointer
    assign empty_o = (sp_q == '0);
    assign top_o   = stack_q[top_idx];  // meaningless when empty

    // pop first, then push into the freed slot
    assign do_pop    = pop_i && !empty_o;
    assign sp_popped = do_pop ? sp_dec : sp_q;
    assign do_push   = push_i && (sp_popped != bpu_pkg::RAS_DEPTH);  // full guard
    assign wr_idx    = sp_popped[bpu_pkg::RAS_PTR_W-2:0];

    always_comb begin
        sp_nxt = sp_popped;
        if (do_push) begin
            sp_nxt = sp_popped + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sp_q <= '0;
        end else begin
            sp_q <= sp_nxt;
        end
    end

    // push and pop together just replace the top
    always_ff @(posedge clk) begin
        if (do_push) begin
            stack_q[wr_idx] <= push_data_i;
        end
    end

endmodule
